//--- Bender.yml
package:
  name: binconv_array

sources:
  # packages first, then the interface and the RTL in dependency order
  - binconv_pkg.sv
  - binconv_ctrl_pkg.sv
  - binconv_ctrl_if.sv
  - binconv_hold_reg.sv
  - binconv_window_map.sv
  - binconv_sequencer.sv
  - binconv_pe.sv
  - binconv_array_top.sv
  - target: test
    files:
      - binconv_checker.sv
      - tb_binconv_array.sv

//--- binconv_array_top.sv
// top level of the binary convolution array, instantiates and wires all blocks
`timescale 1ns/1ps

module binconv_array_top (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  // static configuration, held while a tile is in flight
  input  binconv_ctrl_pkg::filter_mode_e filter_mode_i,
  input  binconv_ctrl_pkg::qw_t          qw_i,
  // activation tile stream
  input  binconv_pkg::act_tile_t         act_data_i,
  input  logic                           act_valid_i,
  output logic                           act_ready_o,
  // weight bit-plane stream, lsb plane first
  input  binconv_pkg::wplane_t           weight_data_i,
  input  logic                           weight_valid_i,
  output logic                           weight_ready_o,
  // result stream, one result per PE
  output binconv_pkg::pres_vec_t         pres_data_o,
  output logic                           pres_valid_o,
  input  logic                           pres_ready_i
);
  import binconv_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // internal wiring
  //////////////////////////////////////////////////////////////////////

  // held tile and its handshake towards the sequencer
  act_tile_t                tile_q;
  logic                     tile_valid;
  logic                     tile_release;
  // per-PE window activations
  pe_act_t [NUM_PE-1:0]     pe_act;
  // raw accumulator outputs and their capture strobe
  pres_vec_t                pres_vec;
  logic                     out_push;

  binconv_ctrl_if u_ctrl_if ();

  // input tile buffer, freed by the sequencer at end of tile
  binconv_hold_reg #(
    .T ( act_tile_t )
  ) u_act_reg (
    .clk_i     ( clk_i        ),
    .rst_ni    ( rst_ni       ),
    .data_i    ( act_data_i   ),
    .valid_i   ( act_valid_i  ),
    .ready_o   ( act_ready_o  ),
    .data_o    ( tile_q       ),
    .valid_o   ( tile_valid   ),
    .release_i ( tile_release )
  );

  binconv_window_map u_window_map (
    .tile_i        ( tile_q        ),
    .filter_mode_i ( filter_mode_i ),
    .pe_act_o      ( pe_act        )
  );

  // weight beats only start when the result slot is truly empty
  binconv_sequencer u_sequencer (
    .clk_i          ( clk_i          ),
    .rst_ni         ( rst_ni         ),
    .qw_i           ( qw_i           ),
    .tile_valid_i   ( tile_valid     ),
    .out_empty_i    ( ~pres_valid_o  ),
    .weight_data_i  ( weight_data_i  ),
    .weight_valid_i ( weight_valid_i ),
    .weight_ready_o ( weight_ready_o ),
    .tile_release_o ( tile_release   ),
    .out_push_o     ( out_push       ),
    .ctrl           ( u_ctrl_if.seq  )
  );

  for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
    binconv_pe u_pe (
      .clk_i  ( clk_i        ),
      .rst_ni ( rst_ni       ),
      .act_i  ( pe_act[p]    ),
      .ctrl   ( u_ctrl_if.pe ),
      .pres_o ( pres_vec[p]  )
    );
  end

  // result buffer, drains on the downstream ready
  // its ready is not needed, pushes only happen into an empty slot
  binconv_hold_reg #(
    .T ( pres_vec_t )
  ) u_out_reg (
    .clk_i     ( clk_i        ),
    .rst_ni    ( rst_ni       ),
    .data_i    ( pres_vec     ),
    .valid_i   ( out_push     ),
    .ready_o   (              ),
    .data_o    ( pres_data_o  ),
    .valid_o   ( pres_valid_o ),
    .release_i ( pres_ready_i )
  );

endmodule

//--- binconv_checker.sv
// protocol and latency assertions for the binary convolution array, bound to the top level
`timescale 1ns/1ps

module binconv_checker (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   act_valid_i,
  input  logic                   act_ready_i,
  input  logic                   last_beat_i,
  input  logic                   weight_ready_i,
  input  binconv_pkg::pres_vec_t pres_data_i,
  input  logic                   pres_valid_i,
  input  logic                   pres_ready_i
);

  // failed assertions so far, read by the testbench
  int unsigned fail_cnt = 0;

  // tile occupancy seen from the ports
  // held from the edge after the tile transfer up to the edge of its last plane
  logic tile_held_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tile_held_q <= 1'b0;
    end else if (act_valid_i && act_ready_i) begin
      tile_held_q <= 1'b1;
    end else if (last_beat_i) begin
      tile_held_q <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // output stream under back-pressure
  //////////////////////////////////////////////////////////////////////

  a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pres_valid_i && !pres_ready_i |=> $stable(pres_data_i))
  else begin
    fail_cnt++;
    $error("result data changed while the output was stalled");
  end

  a_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pres_valid_i && !pres_ready_i |=> pres_valid_i)
  else begin
    fail_cnt++;
    $error("result valid dropped before the result was taken");
  end

  //////////////////////////////////////////////////////////////////////
  // weight acceptance and result latency
  //////////////////////////////////////////////////////////////////////

  // no tile held means no plane may be taken, release cycle included
  a_no_tile_no_weight: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !tile_held_q |-> !weight_ready_i)
  else begin
    fail_cnt++;
    $error("weight ready was high with no tile held");
  end

  // results appear two edges after the last plane, and only then
  a_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
    last_beat_i |-> ##2 $rose(pres_valid_i))
  else begin
    fail_cnt++;
    $error("result valid did not rise two cycles after the last plane");
  end

  a_no_early_valid: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(pres_valid_i) |-> $past(last_beat_i, 2))
  else begin
    fail_cnt++;
    $error("result valid rose without a last plane two cycles before");
  end

endmodule

bind binconv_array_top binconv_checker u_checker (
  .clk_i          ( clk_i          ),
  .rst_ni         ( rst_ni         ),
  .act_valid_i    ( act_valid_i    ),
  .act_ready_i    ( act_ready_o    ),
  .last_beat_i    ( u_ctrl_if.last ),
  .weight_ready_i ( weight_ready_o ),
  .pres_data_i    ( pres_data_o    ),
  .pres_valid_i   ( pres_valid_o   ),
  .pres_ready_i   ( pres_ready_i   )
);

//--- binconv_ctrl_if.sv
// control bundle from the sequencer to the PEs, with sequencer and PE modports
`timescale 1ns/1ps

interface binconv_ctrl_if;
  import binconv_pkg::*;
  import binconv_ctrl_pkg::*;

  // accumulate strobe, one per accepted weight beat
  logic     acc_en;
  // first beat of a tile, PE loads instead of adding
  logic     acc_clear;
  // shift amount for the current plane
  bit_idx_t bit_idx;
  // current bit-plane, shared by all PEs
  wplane_t  wplane;
  // final beat of the tile
  logic     last;

  // sequencer side drives everything
  modport seq (
    output acc_en, acc_clear, bit_idx, wplane, last
  );

  // PE side only needs the accumulate controls and the plane
  modport pe (
    input acc_en, acc_clear, bit_idx, wplane
  );

endinterface

//--- binconv_ctrl_pkg.sv
// filter-mode encoding, weight precision and bit-plane counter types
package binconv_ctrl_pkg;

  // qw runs 1..MAX_QW so it needs one more bit than the plane index
  localparam int unsigned QW_W      = $clog2(binconv_pkg::MAX_QW + 1);
  localparam int unsigned BIT_IDX_W = $clog2(binconv_pkg::MAX_QW);

  // window shape applied by the mapper
  typedef enum logic {
    FILTER_3X3 = 1'b0,
    FILTER_1X1 = 1'b1
  } filter_mode_e;

  // number of weight bit-planes per tile
  typedef logic [QW_W-1:0] qw_t;

  // index of the plane currently on the bus, lsb plane first
  typedef logic [BIT_IDX_W-1:0] bit_idx_t;

endpackage

//--- binconv_hold_reg.sv
// one-entry valid/ready holding register with a generic payload type
`timescale 1ns/1ps

module binconv_hold_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  // upstream side
  input  T     data_i,
  input  logic valid_i,
  output logic ready_o,
  // downstream side
  output T     data_o,
  output logic valid_o,
  // frees the entry at the next edge
  input  logic release_i
);

  logic valid_q;
  T     data_q;
  logic load;

  // empty, or emptied on this edge, so a new entry fits
  assign ready_o = ~valid_q | release_i;
  assign load    = valid_i & ready_o;

  // occupancy flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (load) begin
      // refill wins over release
      valid_q <= 1'b1;
    end else if (release_i) begin
      valid_q <= 1'b0;
    end
  end

  // payload only moves on a load
  always_ff @(posedge clk_i) begin
    if (load) begin
      data_q <= data_i;
    end
  end

  assign data_o  = data_q;
  assign valid_o = valid_q;

endmodule

//--- binconv_pe.sv
// single PE, binary dot product over 9 rows x 4 channels with shift-accumulate
`timescale 1ns/1ps

module binconv_pe (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // window activations for this PE
  input  binconv_pkg::pe_act_t act_i,
  // shared plane and accumulate controls
  binconv_ctrl_if.pe           ctrl,
  // running result
  output binconv_pkg::pres_t   pres_o
);
  import binconv_pkg::*;

  pres_t dot_sum;
  pres_t dot_shifted;
  pres_t acc_q;

  //////////////////////////////////////////////////////////////////////
  // binary dot product
  //////////////////////////////////////////////////////////////////////

  // add every activation whose weight bit is set
  always_comb begin
    dot_sum = '0;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < TP_IN; c++) begin
        if (ctrl.wplane[r][c]) begin
          dot_sum = dot_sum + pres_t'(act_i[r][c]);
        end
      end
    end
  end

  // weight of the current plane is 2^bit_idx
  assign dot_shifted = dot_sum << ctrl.bit_idx;

  //////////////////////////////////////////////////////////////////////
  // accumulator
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q <= '0;
    end else if (ctrl.acc_en) begin
      // first plane overwrites the previous tile's sum
      if (ctrl.acc_clear) begin
        acc_q <= dot_shifted;
      end else begin
        acc_q <= acc_q + dot_shifted;
      end
    end
  end

  assign pres_o = acc_q;

endmodule

//--- binconv_pkg.sv
// array geometry, data widths and payload types of the binary convolution array
package binconv_pkg;

  //////////////////////////////////////////////////////////////////////
  // geometry
  //////////////////////////////////////////////////////////////////////

  // processing elements, laid out as a PE_W wide patch of output pixels
  localparam int unsigned NUM_PE = 4;
  localparam int unsigned PE_W   = 2;
  // input tile size in pixels
  localparam int unsigned BUF_W  = 4;
  localparam int unsigned BUF_H  = 4;
  // channels per pixel
  localparam int unsigned TP_IN  = 4;
  // filter rows seen by one PE (3x3 window)
  localparam int unsigned ROWS   = 9;

  //////////////////////////////////////////////////////////////////////
  // data widths
  //////////////////////////////////////////////////////////////////////

  // unsigned activations
  localparam int unsigned ACT_W   = 4;
  localparam int unsigned NUM_ACT = BUF_H * BUF_W * TP_IN;
  // weight precision, one bit-plane per beat
  localparam int unsigned MAX_QW  = 4;
  // worst case 36 x 15 x 15 = 8100, plenty of headroom
  localparam int unsigned PRES_W  = 16;

  // one activation
  typedef logic [ACT_W-1:0] act_t;
  // whole tile, flat index (y*BUF_W + x)*TP_IN + c
  typedef act_t [NUM_ACT-1:0] act_tile_t;
  // activations routed to one PE, row by channel
  typedef act_t [ROWS-1:0][TP_IN-1:0] pe_act_t;
  // one weight bit-plane, same row by channel layout
  typedef logic [ROWS-1:0][TP_IN-1:0] wplane_t;
  // partial results
  typedef logic [PRES_W-1:0] pres_t;
  typedef pres_t [NUM_PE-1:0] pres_vec_t;

endpackage

//--- binconv_sequencer.sv
// bit-plane counter, weight handshake, accumulate control and tile release
`timescale 1ns/1ps

module binconv_sequencer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // static precision, held while a tile is in flight
  input  binconv_ctrl_pkg::qw_t  qw_i,
  // state of the surrounding holding registers
  input  logic                   tile_valid_i,
  input  logic                   out_empty_i,
  // weight bit-plane stream
  input  binconv_pkg::wplane_t   weight_data_i,
  input  logic                   weight_valid_i,
  output logic                   weight_ready_o,
  // end-of-tile strobes
  output logic                   tile_release_o,
  output logic                   out_push_o,
  // control towards the PEs
  binconv_ctrl_if.seq            ctrl
);
  import binconv_ctrl_pkg::*;

  bit_idx_t cnt_q;
  logic     push_q;
  logic     beat;
  logic     final_plane;

  //////////////////////////////////////////////////////////////////////
  // weight handshake
  //////////////////////////////////////////////////////////////////////

  // only accept planes while a tile is loaded and the result slot is free
  // push_q blocks the release cycle, the old tile is still marked valid there
  assign weight_ready_o = tile_valid_i & out_empty_i & ~push_q;
  assign beat           = weight_valid_i & weight_ready_o;

  // plane number cnt_q+1 is the last one when it equals qw
  assign final_plane = (qw_t'(cnt_q) + qw_t'(1)) == qw_i;

  // PE controls, all aligned with the accepted beat
  assign ctrl.acc_en    = beat;
  assign ctrl.acc_clear = beat & (cnt_q == '0);
  assign ctrl.bit_idx   = cnt_q;
  assign ctrl.wplane    = weight_data_i;
  assign ctrl.last      = beat & final_plane;

  //////////////////////////////////////////////////////////////////////
  // bit-plane counter
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else if (beat) begin
      // wrap to zero so the next tile starts with a clear
      cnt_q <= ctrl.last ? '0 : cnt_q + bit_idx_t'(1);
    end
  end

  // accumulators settle on the last beat edge, results go out one cycle later
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      push_q <= 1'b0;
    end else begin
      push_q <= ctrl.last;
    end
  end

  // free the tile and capture the results together
  assign tile_release_o = push_q;
  assign out_push_o     = push_q;

endmodule

//--- binconv_window_map.sv
// routes the held activation tile to the per-PE filter rows for each filter mode
`timescale 1ns/1ps

module binconv_window_map (
  input  binconv_pkg::act_tile_t                            tile_i,
  input  binconv_ctrl_pkg::filter_mode_e                    filter_mode_i,
  output binconv_pkg::pe_act_t [binconv_pkg::NUM_PE-1:0]    pe_act_o
);
  import binconv_pkg::*;
  import binconv_ctrl_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // static routing, one mux per activation
  //////////////////////////////////////////////////////////////////////

  for (genvar p = 0; p < NUM_PE; p++) begin : g_pe
    // output pixel of this PE inside the patch
    localparam int unsigned PY = p / PE_W;
    localparam int unsigned PX = p % PE_W;
    // 1x1 mode looks at the window centre
    localparam int unsigned PIX_1X1 = (PY + 1) * BUF_W + (PX + 1);

    for (genvar r = 0; r < ROWS; r++) begin : g_row
      // filter row r sits at (r/3, r%3) inside the 3x3 window
      localparam int unsigned PIX_3X3 = (PY + r / 3) * BUF_W + (PX + r % 3);

      for (genvar c = 0; c < TP_IN; c++) begin : g_ch
        act_t act_3x3;
        act_t act_1x1;

        assign act_3x3 = tile_i[PIX_3X3 * TP_IN + c];

        if (r == 0) begin : g_centre
          assign act_1x1 = tile_i[PIX_1X1 * TP_IN + c];
        end else begin : g_unused
          // rows 1..8 carry nothing in 1x1 mode
          assign act_1x1 = '0;
        end

        assign pe_act_o[p][r][c] = (filter_mode_i == FILTER_1X1) ? act_1x1 : act_3x3;
      end
    end
  end

endmodule

//--- flist.f
binconv_pkg.sv
binconv_ctrl_pkg.sv
binconv_ctrl_if.sv
binconv_hold_reg.sv
binconv_window_map.sv
binconv_sequencer.sv
binconv_pe.sv
binconv_array_top.sv
binconv_checker.sv
tb_binconv_array.sv

//--- tb_binconv_array.sv
// testbench for the binary convolution array, with reference model, stimulus and result checks
`timescale 1ns/1ps

module tb_binconv_array;
  import binconv_pkg::*;
  import binconv_ctrl_pkg::*;

  localparam int CLK_PERIOD = 20;
  localparam int NUM_TESTS  = 5;
  localparam int STALL_LEN  = 64;

  logic         clk_i;
  logic         rst_ni;
  filter_mode_e filter_mode_i;
  qw_t          qw_i;
  act_tile_t    act_data_i;
  logic         act_valid_i;
  logic         act_ready_o;
  wplane_t      weight_data_i;
  logic         weight_valid_i;
  logic         weight_ready_o;
  pres_vec_t    pres_data_o;
  logic         pres_valid_o;
  logic         pres_ready_i;

  // bookkeeping
  int                   seed;
  int                   err_cnt;
  int                   n_checks;
  int                   err_start;
  int                   chk_start;
  int                   asrt_start;
  string                cur_test;
  pres_vec_t            exp_q[$];
  logic                 stall_en;
  logic [STALL_LEN-1:0] stall_pat;

  binconv_array_top uut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model: sum of 2^b * act * wbit per PE
  //////////////////////////////////////////////////////////////////////

  function automatic pres_t ref_result(input act_tile_t tile, input wplane_t [MAX_QW-1:0] planes,
                                       input int qw, input filter_mode_e mode, input int p);
    int sum;
    int y;
    int x;
    sum = 0;
    for (int b = 0; b < qw; b++) begin
      for (int r = 0; r < ROWS; r++) begin
        // 1x1 takes the window centre on row 0 only
        y = (mode == FILTER_1X1) ? p / PE_W + 1 : p / PE_W + r / 3;
        x = (mode == FILTER_1X1) ? p % PE_W + 1 : p % PE_W + r % 3;
        for (int c = 0; c < TP_IN; c++) begin
          if (planes[b][r][c] && (mode == FILTER_3X3 || r == 0)) begin
            sum += int'(tile[(y * BUF_W + x) * TP_IN + c]) << b;
          end
        end
      end
    end
    return pres_t'(sum);
  endfunction

  // one random tile, model result queued, then tile beat and qw plane beats
  task automatic run_tile(input logic all_ones);
    act_tile_t            tile;
    wplane_t [MAX_QW-1:0] planes;
    pres_vec_t            exp;
    logic [63:0]          rnd;
    for (int i = 0; i < NUM_ACT; i++) begin
      tile[i] = act_t'($random(seed));
    end
    for (int b = 0; b < MAX_QW; b++) begin
      rnd       = {$random(seed), $random(seed)};
      planes[b] = all_ones ? '1 : rnd[ROWS*TP_IN-1:0];
    end
    for (int p = 0; p < NUM_PE; p++) begin
      exp[p] = ref_result(tile, planes, int'(qw_i), filter_mode_i, p);
    end
    exp_q.push_back(exp);
    act_data_i  = tile;
    act_valid_i = 1'b1;
    // ready is settled by the falling edge, transfer on the next rise
    do begin
      @(negedge clk_i);
    end while (!act_ready_o);
    @(posedge clk_i);
    #2;
    act_valid_i = 1'b0;
    for (int b = 0; b < int'(qw_i); b++) begin
      weight_data_i  = planes[b];
      weight_valid_i = 1'b1;
      do begin
        @(negedge clk_i);
      end while (!weight_ready_o);
      @(posedge clk_i);
      #2;
    end
    weight_valid_i = 1'b0;
  endtask

  task automatic check_level(input string sig, input logic exp, input logic act);
    assert (act === exp) else begin
      $display("FAILED %s %s expected %b actual %b", cur_test, sig, exp, act);
      err_cnt++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test   = name;
    err_start  = err_cnt;
    chk_start  = n_checks;
    asrt_start = uut.u_checker.fail_cnt;
  endtask

  // waits until every queued result has been compared
  task automatic end_test();
    int errs;
    while (exp_q.size() != 0) begin
      @(posedge clk_i);
      #2;
    end
    errs = err_cnt - err_start + (uut.u_checker.fail_cnt - asrt_start);
    $display("test %-20s done, %0d results checked, %0d errors",
             cur_test, n_checks - chk_start, errs);
  endtask

  //////////////////////////////////////////////////////////////////////
  // output side: ready pattern and result compare
  //////////////////////////////////////////////////////////////////////

  initial begin : ready_gen
    int cyc;
    cyc = 0;
    forever begin
      @(posedge clk_i);
      #2;
      pres_ready_i = stall_en ? stall_pat[cyc % STALL_LEN] : 1'b1;
      cyc++;
    end
  end

  initial begin : out_monitor
    pres_vec_t exp;
    forever begin
      @(negedge clk_i);
      if (rst_ni && pres_valid_o && pres_ready_i) begin
        n_checks++;
        assert (exp_q.size() != 0) else begin
          $display("ERROR %s: a result came out with no tile pending", cur_test);
          err_cnt++;
        end
        if (exp_q.size() != 0) begin
          exp = exp_q.pop_front();
          assert (pres_data_o == exp) else begin
            $display("FAILED %s expected %h actual %h", cur_test, exp, pres_data_o);
            err_cnt++;
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (NUM_TESTS * 200) @(posedge clk_i);
    $display("ERROR: the run did not finish within %0d cycles", NUM_TESTS * 200);
    $display("Testbench failed");
    $finish;
  end

  initial begin : main_seq
    logic level;
    int   idx;
    int   run;
    int   total_fail;
    seed           = 32'h9743;
    err_cnt        = 0;
    n_checks       = 0;
    cur_test       = "reset";
    rst_ni         = 1'b0;
    filter_mode_i  = FILTER_3X3;
    qw_i           = qw_t'(1);
    act_data_i     = '0;
    act_valid_i    = 1'b0;
    weight_data_i  = '0;
    weight_valid_i = 1'b0;
    pres_ready_i   = 1'b1;
    stall_en       = 1'b0;
    stall_pat      = '0;
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;

    start_test("reset_state");
    @(negedge clk_i);
    check_level("act_ready_o", 1'b1, act_ready_o);
    check_level("weight_ready_o", 1'b0, weight_ready_o);
    check_level("pres_valid_o", 1'b0, pres_valid_o);
    @(posedge clk_i);
    #2;
    end_test();

    // all-ones single plane gives plain window sums
    start_test("conv3x3_qw1_ones");
    repeat (3) run_tile(1'b1);
    end_test();

    start_test("conv3x3_qw4_random");
    qw_i = qw_t'(4);
    repeat (4) run_tile(1'b0);
    end_test();

    // weights on rows 1..8 are random and must not count
    start_test("conv1x1_random");
    filter_mode_i = FILTER_1X1;
    qw_i          = qw_t'(3);
    repeat (4) run_tile(1'b0);
    end_test();

    // stall stretches of 1..8 cycles, alternating low and high
    start_test("backpressure_stream");
    filter_mode_i = FILTER_3X3;
    qw_i          = qw_t'(4);
    level         = 1'b0;
    idx           = 0;
    while (idx < STALL_LEN) begin
      run = 1 + ($random(seed) & 7);
      for (int k = 0; k < run && idx < STALL_LEN; k++) begin
        stall_pat[idx] = level;
        idx++;
      end
      level = ~level;
    end
    @(negedge clk_i);
    stall_en = 1'b1;
    @(posedge clk_i);
    #2;
    repeat (6) run_tile(1'b0);
    end_test();

    total_fail = err_cnt + uut.u_checker.fail_cnt;
    $display("summary: %0d tests, %0d results checked, %0d mismatches, %0d assertion failures",
             NUM_TESTS, n_checks, err_cnt, uut.u_checker.fail_cnt);
    if (total_fail == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule
